/* list.f */
rtl/CorePkg.sv
rtl/ChannelFifo.sv
rtl/PcParser.sv
rtl/TimeMgr.sv
rtl/SpikeGenArray.sv
rtl/TagMerge.sv
rtl/Core.sv
sim/CoreAsserts.sv
sim/CoreChecker.sv
sim/CoreTb.sv

/* run.sh */
#!/bin/sh
# Build and run the Core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module CoreTb -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/VCoreTb 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "No errors"; then
  exit 0
fi
exit 1

/* sim/CoreTb.sv */
`timescale 1ns/10ps
`default_nettype none

module CoreTb;

  import CorePkg::*;

  localparam int nGens = 8;
  localparam int nTime = 48;
  localparam int nUnit = 16;
  localparam int fifoDepth = 4;
  localparam int nRounds = 3;
  localparam int nWords = 120;
  // First register address past the tag slots
  localparam int firstFree = int'(regGenTagBase) + nGens;
  localparam int readyLimit = 200;
  localparam int drainLimit = 600;
  localparam int quietCycles = 30;

  logic clk;
  logic rstN;
  pcWordT pcIn;
  logic pcInValid;
  logic pcInReady;
  bdWordT bdOut;
  logic bdOutValid;
  logic bdOutReady;
  logic [nTime-1:0] timeElapsed;
  // Round boundary marker for the checker
  logic drained;
  logic stallOn;
  int errorCount;
  int wordCount;
  int timeouts;

  Core #(.nGens(nGens), .nTime(nTime), .nUnit(nUnit), .fifoDepth(fifoDepth)) i_Core (
    .clk(clk), .rstN(rstN),
    .pcIn(pcIn), .pcInValid(pcInValid), .pcInReady(pcInReady),
    .bdOut(bdOut), .bdOutValid(bdOutValid), .bdOutReady(bdOutReady),
    .timeElapsed(timeElapsed)
  );

  CoreChecker #(.nGens(nGens), .nTime(nTime)) coreCheck (
    .clk(clk), .rstN(rstN),
    .pcIn(pcIn), .pcInValid(pcInValid), .pcInReady(pcInReady),
    .bdOut(bdOut), .bdOutValid(bdOutValid), .bdOutReady(bdOutReady),
    .timeElapsed(timeElapsed), .drained(drained),
    .errorCount(errorCount), .wordCount(wordCount)
  );

  // Handshake checks inside the DUT
  bind Core CoreAsserts coreAsserts (
    .clk(clk), .rstN(rstN),
    .pcWord(pcWord), .pcWordValid(pcWordValid), .pcWordReady(pcWordReady),
    .bdOut(bdOut), .bdOutValid(bdOutValid), .bdOutReady(bdOutReady),
    .fwd(fwd), .fwdValid(fwdValid), .fwdReady(fwdReady),
    .genTagWord(genTagWord), .genTagValid(genTagValid), .genTagReady(genTagReady)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  //////////////////////////////
  // Stimulus helpers

  // Wait for the edge and drive 1 ns after it
  task automatic tick();
    @(posedge clk);
    #1;
    // About 30% stall on the chip side
    bdOutReady = stallOn ? 1'($urandom % 10 < 7) : 1'b1;
  endtask

  task automatic sendWord(input pcWordT w);
    int waited;
    pcIn = w;
    pcInValid = 1'b1;
    waited = 0;
    // Ready only moves on an edge so it is stable here
    while (!pcInReady && waited < readyLimit) begin
      tick();
      waited++;
    end
    if (!pcInReady) begin
      $display("Timeout: the input FIFO did not accept a PC word");
      timeouts++;
    end
    tick();
    pcInValid = 1'b0;
  endtask

  task automatic sendConf(input logic [7:0] addr, input logic [15:0] val);
    pcWordT w;
    w.code = codeConfWrite;
    w.data = {addr, val};
    sendWord(w);
  endtask

  // Periods and tags first and the enable mask last, all while timeUnit is 0
  task automatic writeConfig();
    logic [15:0] mask;
    for (int i = 0; i < nGens; i++) begin
      sendConf(8'(regGenPeriodBase + i), 16'(1 + $urandom % 6));
      sendConf(8'(regGenTagBase + i), 16'($urandom % 2048));
    end
    mask = 16'($urandom % (1 << nGens));
    if (mask == '0) begin
      mask = 16'd1;
    end
    sendConf(regGenEnable, mask);
  endtask

  task automatic runTraffic();
    pcWordT w;
    int pick;
    sendConf(regTimeUnit, 16'(2 + $urandom % 4));
    stallOn = 1'b1;
    for (int n = 0; n < nWords; n++) begin
      pick = int'($urandom % 10);
      // Mix of BD words, unknown codes and unused-address writes
      if (pick < 7) begin
        w.code = codeBdWord;
      end else if (pick == 7) begin
        w.code = 8'(2 + $urandom % 254);
      end else begin
        w.code = codeConfWrite;
      end
      w.data = 24'($urandom);
      if (pick >= 8) begin
        w.data[23:16] = 8'(firstFree + $urandom % (256 - firstFree));
      end
      sendWord(w);
    end
    stallOn = 1'b0;
  endtask

  // Quiet means no chip word and no time step for a while
  task automatic waitDrain();
    int quiet;
    int waited;
    logic [nTime-1:0] lastT;
    quiet = 0;
    waited = 0;
    lastT = timeElapsed;
    while (quiet < quietCycles && waited < drainLimit) begin
      tick();
      waited++;
      if (bdOutValid || timeElapsed != lastT) begin
        quiet = 0;
      end else begin
        quiet++;
      end
      lastT = timeElapsed;
    end
    if (quiet < quietCycles) begin
      $display("Timeout: the chip-bound stream did not drain");
      timeouts++;
    end
  endtask

  task automatic drainRound();
    sendConf(regTimeUnit, 16'd0);
    waitDrain();
    drained = 1'b1;
    tick();
    drained = 1'b0;
  endtask

  //////////////////////////////
  // Main sequence

  initial begin
    void'($urandom(32'h0c11_273d));
    rstN = 1'b0;
    pcIn = '0;
    pcInValid = 1'b0;
    bdOutReady = 1'b1;
    drained = 1'b0;
    stallOn = 1'b0;
    timeouts = 0;
    repeat (16) tick();
    rstN = 1'b1;
    tick();
    for (int r = 0; r < nRounds; r++) begin
      writeConfig();
      runTraffic();
      drainRound();
    end
    repeat (4) tick();
    $display("Checked %0d chip words: %0d value errors, %0d timeouts",
             wordCount, errorCount, timeouts);
    if (errorCount == 0 && timeouts == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sim/CoreChecker.sv */
`timescale 1ns/10ps
`default_nettype none

module CoreChecker #(
  parameter int nGens = CorePkg::nGensDef,
  parameter int nTime = CorePkg::nTimeDef
) (
  input logic clk,
  input logic rstN,
  input CorePkg::pcWordT pcIn,
  input logic pcInValid,
  input logic pcInReady,
  input CorePkg::bdWordT bdOut,
  input logic bdOutValid,
  input logic bdOutReady,
  input logic [nTime-1:0] timeElapsed,
  input logic drained,
  output int errorCount,
  output int wordCount
);

  import CorePkg::*;

  // Expected forwarded payloads, oldest first
  logic [payloadW-1:0] fwdQ[$];
  // Model of the configuration registers
  int unitM;
  logic [nGens-1:0] enM;
  int periodM[nGens];
  int tagM[nGens];
  // Model countdowns and firings this round
  int cdM[nGens];
  int firedM[nGens];
  // Counts received and expected, keyed by tag
  int rxByTag[int];
  int expByTag[int];
  logic [nTime-1:0] lastTime;
  // Set while elapsed time must hold still
  logic frozen;

  task automatic resetModel();
    fwdQ.delete();
    unitM = 0;
    enM = '0;
    for (int i = 0; i < nGens; i++) begin
      periodM[i] = 0;
      tagM[i] = 0;
      cdM[i] = 0;
      firedM[i] = 0;
    end
    rxByTag.delete();
    lastTime = '0;
    frozen = 1'b1;
  endtask

  task automatic applyWrite(input int addr, input int val);
    if (addr == int'(regTimeUnit)) begin
      unitM = val;
      if (val != 0) begin
        frozen = 1'b0;
      end
    end else if (addr == int'(regGenEnable)) begin
      enM = val[nGens-1:0];
    end else if (addr >= int'(regGenPeriodBase) && addr < int'(regGenPeriodBase) + nGens) begin
      periodM[addr - int'(regGenPeriodBase)] = val;
    end else if (addr >= int'(regGenTagBase) && addr < int'(regGenTagBase) + nGens) begin
      tagM[addr - int'(regGenTagBase)] = val & 32'h7ff;
    end
    // Disabled generators track their period
    for (int i = 0; i < nGens; i++) begin
      if (!enM[i]) begin
        cdM[i] = periodM[i];
      end
    end
  endtask

  // One time unit elapsed
  task automatic stepGenerators();
    for (int i = 0; i < nGens; i++) begin
      if (!enM[i]) begin
        cdM[i] = periodM[i];
      end else if (periodM[i] != 0) begin
        if (cdM[i] <= 1) begin
          firedM[i]++;
          cdM[i] = periodM[i];
        end else begin
          cdM[i]--;
        end
      end
    end
  endtask

  task automatic checkTime();
    if (timeElapsed < lastTime) begin
      $display("[ERROR] %0t: timeElapsed fell from %0d to %0d", $time, lastTime, timeElapsed);
      errorCount++;
    end else if (timeElapsed > lastTime + 1'b1) begin
      $display("[ERROR] %0t: timeElapsed jumped from %0d to %0d", $time, lastTime, timeElapsed);
      errorCount++;
    end else if (frozen && timeElapsed != lastTime) begin
      $display("[ERROR] %0t: timeElapsed moved to %0d with timeUnit 0", $time, timeElapsed);
      errorCount++;
    end else if (timeElapsed == lastTime + 1'b1) begin
      stepGenerators();
    end
    lastTime = timeElapsed;
  endtask

  task automatic takePcWord();
    if (pcIn.code == codeBdWord) begin
      fwdQ.push_back(pcIn.data[payloadW-1:0]);
    end else if (pcIn.code == codeConfWrite) begin
      applyWrite(int'(pcIn.data[23:16]), int'(pcIn.data[15:0]));
    end
  endtask

  task automatic checkChipWord();
    tagCtT tc;
    logic [payloadW-1:0] expFwd;
    logic known;
    wordCount++;
    if (bdOut.kind == kindFwd) begin
      if (fwdQ.size() == 0) begin
        $display("[ERROR] %0t: forwarded word %h with none expected", $time, bdOut.payload);
        errorCount++;
      end else begin
        expFwd = fwdQ.pop_front();
        if (bdOut.payload != expFwd) begin
          $display("[ERROR] %0t: forwarded word %h, expected %h", $time, bdOut.payload, expFwd);
          errorCount++;
        end
      end
    end else begin
      tc = bdOut.payload;
      known = 1'b0;
      for (int i = 0; i < nGens; i++) begin
        if (enM[i] && tagM[i] == int'(tc.tag)) begin
          known = 1'b1;
        end
      end
      if (!known) begin
        $display("[ERROR] %0t: tag %h belongs to no enabled generator", $time, tc.tag);
        errorCount++;
      end
      if (tc.ct == '0) begin
        $display("[ERROR] %0t: tag %h carries a zero count", $time, tc.tag);
        errorCount++;
      end
      if (rxByTag.exists(int'(tc.tag))) begin
        rxByTag[int'(tc.tag)] += int'(tc.ct);
      end else begin
        rxByTag[int'(tc.tag)] = int'(tc.ct);
      end
    end
  endtask

  // Stream is quiet, every firing must have arrived
  task automatic compareCounts();
    int got;
    if (fwdQ.size() != 0) begin
      $display("[ERROR] %0t: %0d forwarded words missing after drain", $time, fwdQ.size());
      errorCount++;
    end
    expByTag.delete();
    for (int i = 0; i < nGens; i++) begin
      if (firedM[i] != 0) begin
        if (expByTag.exists(tagM[i])) begin
          expByTag[tagM[i]] += firedM[i];
        end else begin
          expByTag[tagM[i]] = firedM[i];
        end
      end
    end
    foreach (expByTag[t]) begin
      got = rxByTag.exists(t) ? rxByTag[t] : 0;
      if (got != expByTag[t]) begin
        $display("[ERROR] %0t: tag %h count %0d, expected %0d", $time, t, got, expByTag[t]);
        errorCount++;
      end
    end
    foreach (rxByTag[t]) begin
      if (!expByTag.exists(t)) begin
        $display("[ERROR] %0t: tag %h count %0d, expected 0", $time, t, rxByTag[t]);
        errorCount++;
      end
    end
    // Next round starts from zero
    for (int i = 0; i < nGens; i++) begin
      firedM[i] = 0;
    end
    rxByTag.delete();
    fwdQ.delete();
    frozen = (unitM == 0);
  endtask

  //////////////////////////////
  // Per-edge sampling

  always @(posedge clk) begin
    if (!rstN) begin
      resetModel();
    end else begin
      // Pulses use the configuration before this edge's writes
      checkTime();
      if (bdOutValid && bdOutReady) begin
        checkChipWord();
      end
      if (pcInValid && pcInReady) begin
        takePcWord();
      end
      if (drained) begin
        compareCounts();
      end
    end
  end

endmodule

`default_nettype wire

/* sim/CoreAsserts.sv */
`timescale 1ns/10ps
`default_nettype none

module CoreAsserts (
  input logic clk,
  input logic rstN,
  input CorePkg::pcWordT pcWord,
  input logic pcWordValid,
  input logic pcWordReady,
  input CorePkg::bdWordT bdOut,
  input logic bdOutValid,
  input logic bdOutReady,
  input logic [CorePkg::payloadW-1:0] fwd,
  input logic fwdValid,
  input logic fwdReady,
  input CorePkg::tagCtT genTagWord,
  input logic genTagValid,
  input logic genTagReady
);

  //////////////////////////////
  // Stalled streams hold their word

  pcHeld: assert property (@(posedge clk) disable iff (!rstN)
    pcWordValid && !pcWordReady |=> pcWordValid && $stable(pcWord))
    else $error("Input FIFO word changed or dropped while the parser was stalled");

  fwdHeld: assert property (@(posedge clk) disable iff (!rstN)
    fwdValid && !fwdReady |=> fwdValid && $stable(fwd))
    else $error("Forwarded word changed or dropped while stalled");

  tagHeld: assert property (@(posedge clk) disable iff (!rstN)
    genTagValid && !genTagReady |=> genTagValid && $stable(genTagWord))
    else $error("Generator tag word changed or dropped while stalled");

  bdHeld: assert property (@(posedge clk) disable iff (!rstN)
    bdOutValid && !bdOutReady |=> bdOutValid && $stable(bdOut))
    else $error("Chip word changed or dropped while stalled");

  // Nothing valid coming out of reset
  resetQuiet: assert property (@(posedge clk)
    !rstN |=> !bdOutValid && !fwdValid && !genTagValid && !pcWordValid)
    else $error("A valid was high right after a reset cycle");

endmodule

`default_nettype wire

/* rtl/Core.sv */
`timescale 1ns/10ps
`default_nettype none

module Core #(
  parameter int nGens = CorePkg::nGensDef,
  parameter int nTime = CorePkg::nTimeDef,
  parameter int nUnit = CorePkg::nUnitDef,
  parameter int fifoDepth = CorePkg::fifoDepthDef
) (
  input logic clk,
  input logic rstN,
  // PC side
  input CorePkg::pcWordT pcIn,
  input logic pcInValid,
  output logic pcInReady,
  // Chip side
  output CorePkg::bdWordT bdOut,
  output logic bdOutValid,
  input logic bdOutReady,
  output logic [nTime-1:0] timeElapsed
);

  import CorePkg::*;

  //////////////////////////////
  // Internal streams

  // PC words past the input FIFO
  pcWordT pcWord;
  logic pcWordValid;
  logic pcWordReady;
  // Forwarded BD payloads
  logic [payloadW-1:0] fwd;
  logic fwdValid;
  logic fwdReady;
  // Tags before and after the tag FIFO
  tagCtT genTagWord;
  logic genTagValid;
  logic genTagReady;
  tagCtT mergeTag;
  logic mergeTagValid;
  logic mergeTagReady;

  // Configuration and timing
  logic [nUnit-1:0] timeUnit;
  logic [nGens-1:0] genEnable;
  logic [nGens-1:0][confW-1:0] genPeriod;
  logic [nGens-1:0][tagW-1:0] genTag;
  logic unitPulse;

  //////////////////////////////
  // Blocks

  ChannelFifo #(.depth(fifoDepth), .payloadT(pcWordT)) inFifo (
    .clk, .rstN,
    .inData(pcIn), .inValid(pcInValid), .inReady(pcInReady),
    .outData(pcWord), .outValid(pcWordValid), .outReady(pcWordReady)
  );

  PcParser #(.nGens(nGens)) pcParser (
    .clk, .rstN,
    .pcWord, .pcValid(pcWordValid), .pcReady(pcWordReady),
    .fwd, .fwdValid, .fwdReady,
    .timeUnit, .genEnable, .genPeriod, .genTag
  );

  TimeMgr #(.nUnit(nUnit), .nTime(nTime)) timeMgr (
    .clk, .rstN, .timeUnit, .unitPulse, .timeElapsed
  );

  SpikeGenArray #(.nGens(nGens)) spikeGenArray (
    .clk, .rstN, .unitPulse, .genEnable, .genPeriod, .genTag,
    .tag(genTagWord), .tagValid(genTagValid), .tagReady(genTagReady)
  );

  // Absorbs tag bursts while the chip side is busy
  ChannelFifo #(.depth(fifoDepth), .payloadT(tagCtT)) tagFifo (
    .clk, .rstN,
    .inData(genTagWord), .inValid(genTagValid), .inReady(genTagReady),
    .outData(mergeTag), .outValid(mergeTagValid), .outReady(mergeTagReady)
  );

  TagMerge tagMerge (
    .clk, .rstN,
    .fwd, .fwdValid, .fwdReady,
    .tag(mergeTag), .tagValid(mergeTagValid), .tagReady(mergeTagReady),
    .bdOut, .bdOutValid, .bdOutReady
  );

endmodule

`default_nettype wire

/* rtl/TagMerge.sv */
`timescale 1ns/10ps
`default_nettype none

module TagMerge (
  input logic clk,
  input logic rstN,
  input logic [CorePkg::payloadW-1:0] fwd,
  input logic fwdValid,
  output logic fwdReady,
  input CorePkg::tagCtT tag,
  input logic tagValid,
  output logic tagReady,
  output CorePkg::bdWordT bdOut,
  output logic bdOutValid,
  input logic bdOutReady
);

  import CorePkg::*;

  logic canLoad;
  logic pickTag;
  logic anyValid;
  // Set when a tag won the last load
  logic lastTag;

  //////////////////////////////
  // Arbitration

  // Output slot free or draining this cycle
  assign canLoad = !bdOutValid || bdOutReady;
  assign anyValid = fwdValid || tagValid;

  // Tag wins alone, or on a tie when forward won last
  assign pickTag = tagValid && (!fwdValid || !lastTag);

  // Both stalled while the output word is held
  assign fwdReady = canLoad && !pickTag;
  assign tagReady = canLoad && pickTag;

  //////////////////////////////
  // Output register

  always_ff @(posedge clk) begin
    if (!rstN) begin
      bdOutValid <= 1'b0;
      lastTag <= 1'b0;
    end else if (canLoad && anyValid) begin
      bdOutValid <= 1'b1;
      lastTag <= pickTag;
    end else if (bdOutReady) begin
      bdOutValid <= 1'b0;
    end
  end

  // Kind bit above the chosen payload
  always_ff @(posedge clk) begin
    if (canLoad && anyValid) begin
      if (pickTag) begin
        bdOut.kind <= kindTag;
        bdOut.payload <= tag;
      end else begin
        bdOut.kind <= kindFwd;
        bdOut.payload <= fwd;
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/SpikeGenArray.sv */
`timescale 1ns/10ps
`default_nettype none

module SpikeGenArray #(
  parameter int nGens = CorePkg::nGensDef
) (
  input logic clk,
  input logic rstN,
  input logic unitPulse,
  input logic [nGens-1:0] genEnable,
  input logic [nGens-1:0][CorePkg::confW-1:0] genPeriod,
  input logic [nGens-1:0][CorePkg::tagW-1:0] genTag,
  output CorePkg::tagCtT tag,
  output logic tagValid,
  input logic tagReady
);

  import CorePkg::*;

  localparam int idxW = (nGens > 1) ? $clog2(nGens) : 1;
  // Pending count saturates here
  localparam logic [ctW-1:0] ctMax = '1;

  logic [nGens-1:0][confW-1:0] countdown;
  logic [nGens-1:0][ctW-1:0] pending;
  logic [nGens-1:0] fire;
  logic [idxW-1:0] rrPtr;
  logic [idxW-1:0] sel;
  logic found;
  logic load;

  //////////////////////////////
  // Generators

  // Fires on the pulse that takes the countdown to zero
  always_comb begin
    for (int i = 0; i < nGens; i++) begin
      fire[i] = unitPulse && genEnable[i] && (genPeriod[i] != '0) &&
                (countdown[i] <= confW'(1));
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      countdown <= '0;
      pending <= '0;
    end else begin
      for (int i = 0; i < nGens; i++) begin
        // Disabled generators sit at a full period
        if (!genEnable[i] || fire[i]) begin
          countdown[i] <= genPeriod[i];
        end else if (unitPulse && genPeriod[i] != '0) begin
          countdown[i] <= countdown[i] - 1'b1;
        end
        // Taken count restarts, keeping a firing from the same cycle
        if (load && sel == idxW'(i)) begin
          pending[i] <= ctW'(fire[i]);
        end else if (fire[i] && pending[i] != ctMax) begin
          pending[i] <= pending[i] + 1'b1;
        end
      end
    end
  end

  //////////////////////////////
  // Round-robin output

  // First generator with a pending count, starting at rrPtr
  always_comb begin
    int j;
    found = 1'b0;
    sel = rrPtr;
    for (int k = 0; k < nGens; k++) begin
      j = (int'(rrPtr) + k) % nGens;
      if (!found && pending[j] != '0) begin
        found = 1'b1;
        sel = idxW'(j);
      end
    end
  end

  // Output register empty or emptying
  assign load = found && (!tagValid || tagReady);

  always_ff @(posedge clk) begin
    if (!rstN) begin
      tagValid <= 1'b0;
      rrPtr <= '0;
    end else if (load) begin
      tagValid <= 1'b1;
      // Next search begins past the winner
      rrPtr <= (sel == idxW'(nGens - 1)) ? '0 : sel + 1'b1;
    end else if (tagReady) begin
      tagValid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      tag.tag <= genTag[sel];
      tag.ct <= pending[sel];
    end
  end

endmodule

`default_nettype wire

/* rtl/TimeMgr.sv */
`timescale 1ns/10ps
`default_nettype none

module TimeMgr #(
  parameter int nUnit = CorePkg::nUnitDef,
  parameter int nTime = CorePkg::nTimeDef
) (
  input logic clk,
  input logic rstN,
  input logic [nUnit-1:0] timeUnit,
  output logic unitPulse,
  output logic [nTime-1:0] timeElapsed
);

  logic [nUnit-1:0] cycleCt;
  // Last seen unit, a change restarts the divider
  logic [nUnit-1:0] lastUnit;
  logic unitChanged;
  logic unitDone;

  assign unitChanged = (timeUnit != lastUnit);
  // Last cycle of the current unit
  assign unitDone = (timeUnit != '0) && (cycleCt == timeUnit - 1'b1);

  // Pulse and elapsed count change on the same edge
  always_ff @(posedge clk) begin
    if (!rstN) begin
      cycleCt <= '0;
      lastUnit <= '0;
      unitPulse <= 1'b0;
      timeElapsed <= '0;
    end else begin
      lastUnit <= timeUnit;
      if (unitChanged || timeUnit == '0) begin
        // Divider idle or restarting
        cycleCt <= '0;
        unitPulse <= 1'b0;
      end else if (unitDone) begin
        cycleCt <= '0;
        unitPulse <= 1'b1;
        timeElapsed <= timeElapsed + 1'b1;
      end else begin
        cycleCt <= cycleCt + 1'b1;
        unitPulse <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/PcParser.sv */
`timescale 1ns/10ps
`default_nettype none

module PcParser #(
  parameter int nGens = CorePkg::nGensDef
) (
  input logic clk,
  input logic rstN,
  input CorePkg::pcWordT pcWord,
  input logic pcValid,
  output logic pcReady,
  output logic [CorePkg::payloadW-1:0] fwd,
  output logic fwdValid,
  input logic fwdReady,
  output logic [CorePkg::confW-1:0] timeUnit,
  output logic [nGens-1:0] genEnable,
  output logic [nGens-1:0][CorePkg::confW-1:0] genPeriod,
  output logic [nGens-1:0][CorePkg::tagW-1:0] genTag
);

  import CorePkg::*;

  logic accept;
  logic isBd;
  logic isConf;
  logic [regAddrW-1:0] confAddr;
  logic [confW-1:0] confVal;

  //////////////////////////////
  // Input decode

  // Take a word when the forward slot is free or draining now
  assign pcReady = !fwdValid || fwdReady;
  assign accept = pcValid && pcReady;

  assign isBd = accept && (pcWord.code == codeBdWord);
  assign isConf = accept && (pcWord.code == codeConfWrite);
  // Address in data 23:16, value in 15:0
  assign confAddr = pcWord.data[pcDataW-1 -: regAddrW];
  assign confVal = pcWord.data[confW-1:0];

  //////////////////////////////
  // Forward register

  always_ff @(posedge clk) begin
    if (!rstN) begin
      fwdValid <= 1'b0;
    end else if (isBd) begin
      fwdValid <= 1'b1;
    end else if (fwdReady) begin
      fwdValid <= 1'b0;
    end
  end

  // only the BD word payload is kept, code is dropped
  always_ff @(posedge clk) begin
    if (isBd) begin
      fwd <= pcWord.data[payloadW-1:0];
    end
  end

  //////////////////////////////
  // Configuration registers

  always_ff @(posedge clk) begin
    if (!rstN) begin
      timeUnit <= '0;
      genEnable <= '0;
      genPeriod <= '0;
      genTag <= '0;
    end else if (isConf) begin
      if (confAddr == regTimeUnit) begin
        timeUnit <= confVal;
      end
      if (confAddr == regGenEnable) begin
        genEnable <= confVal[nGens-1:0];
      end
      // Per-generator slots, unmatched addresses fall through
      for (int i = 0; i < nGens; i++) begin
        if (confAddr == regGenPeriodBase + regAddrW'(i)) begin
          genPeriod[i] <= confVal;
        end
        if (confAddr == regGenTagBase + regAddrW'(i)) begin
          genTag[i] <= confVal[tagW-1:0];
        end
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/ChannelFifo.sv */
`timescale 1ns/10ps
`default_nettype none

module ChannelFifo #(
  parameter int depth = 4,
  parameter type payloadT = logic [31:0]
) (
  input logic clk,
  input logic rstN,
  input payloadT inData,
  input logic inValid,
  output logic inReady,
  output payloadT outData,
  output logic outValid,
  input logic outReady
);

  // Pointer needs at least one bit even for a single entry
  localparam int ptrW = (depth > 1) ? $clog2(depth) : 1;
  localparam int countW = $clog2(depth + 1);

  payloadT mem [depth];
  logic [ptrW-1:0] rdPtr;
  logic [ptrW-1:0] wrPtr;
  logic [countW-1:0] count;
  logic push;
  logic pop;

  // Wrap at depth, works for any depth
  function automatic logic [ptrW-1:0] nextPtr(input logic [ptrW-1:0] ptr);
    if (ptr == ptrW'(depth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // Room left while below depth
  assign inReady = (count < countW'(depth));
  assign outValid = (count != '0);
  // Head of queue straight from storage
  assign outData = mem[rdPtr];

  assign push = inValid && inReady;
  assign pop = outValid && outReady;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      rdPtr <= '0;
      wrPtr <= '0;
      count <= '0;
    end else begin
      if (push) begin
        wrPtr <= nextPtr(wrPtr);
      end
      if (pop) begin
        rdPtr <= nextPtr(rdPtr);
      end
      // Occupancy, unchanged when both or neither happen
      case ({push, pop})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Storage
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wrPtr] <= inData;
    end
  end

endmodule

`default_nettype wire

/* rtl/CorePkg.sv */
`default_nettype none

package CorePkg;

  //////////////////////////////
  // Field widths

  // PC word split
  localparam int pcCodeW = 8;
  localparam int pcDataW = 24;
  // Config write split, address above value
  localparam int regAddrW = 8;
  localparam int confW = 16;
  // Tag word split
  localparam int tagW = 11;
  localparam int ctW = 9;
  localparam int payloadW = tagW + ctW;

  //////////////////////////////
  // Word types

  typedef struct packed {
    logic [pcCodeW-1:0] code;
    logic [pcDataW-1:0] data;
  } pcWordT;

  // Chip-bound word, kind above payload
  typedef struct packed {
    logic kind;
    logic [payloadW-1:0] payload;
  } bdWordT;

  typedef struct packed {
    logic [tagW-1:0] tag;
    logic [ctW-1:0] ct;
  } tagCtT;

  // PC codes
  localparam logic [pcCodeW-1:0] codeBdWord = 8'd0;
  localparam logic [pcCodeW-1:0] codeConfWrite = 8'd1;

  // Chip word kinds
  localparam logic kindFwd = 1'b0;
  localparam logic kindTag = 1'b1;

  // Register map, one period and one tag address per generator
  localparam logic [regAddrW-1:0] regTimeUnit = 8'd0;
  localparam logic [regAddrW-1:0] regGenEnable = 8'd1;
  localparam logic [regAddrW-1:0] regGenPeriodBase = 8'd2;
  localparam logic [regAddrW-1:0] regGenTagBase = 8'd10;

  // Top level defaults
  localparam int nGensDef = 8;
  localparam int nTimeDef = 48;
  localparam int nUnitDef = 16;
  localparam int fifoDepthDef = 4;

endpackage

`default_nettype wire
